// ==== logic/stm_pkg.sv ====
package stm_pkg;

  // ========================================
  // Array geometry
  // ========================================
  localparam int num_trans    = 16;  // 4 x 4 grid.
  localparam int grid_cols    = 4;
  localparam int trans_pitch  = 10;  // Position units between neighbors.
  localparam int max_patterns = 16;
  localparam logic [3:0] last_trans = 4'(num_trans - 1);

  // ========================================
  // Pattern memory
  // ========================================
  localparam int mem_depth = 256;    // 8 bit address.

  // ========================================
  // Register offsets
  // ========================================
  localparam logic [7:0] reg_ctrl        = 8'h00;  // Bit 0 is gain_mode.
  localparam logic [7:0] reg_cycle       = 8'h04;
  localparam logic [7:0] reg_freq_div    = 8'h08;
  localparam logic [7:0] reg_sound_speed = 8'h0C;
  localparam logic [7:0] reg_mem_lo      = 8'h10;
  localparam logic [7:0] reg_mem_hi      = 8'h14;
  localparam logic [7:0] reg_mem_addr    = 8'h18;  // Write commits the word.

  // Focus operator FSM encoding.
  localparam logic [2:0] st_idle   = 3'd0;
  localparam logic [2:0] st_fetch  = 3'd1;
  localparam logic [2:0] st_load   = 3'd2;
  localparam logic [2:0] st_square = 3'd3;
  localparam logic [2:0] st_root   = 3'd4;
  localparam logic [2:0] st_out    = 3'd5;

  // One memory word, read as a gain entry or as a focal point.
  typedef union packed {
    struct packed {
      logic [47:0] rsvd;
      logic [7:0]  phase;
      logic [7:0]  intensity;  // Bits 7:0.
    } gain;
    struct packed {
      logic [7:0]         rsvd;
      logic [7:0]         intensity;  // Bits 55:48.
      logic signed [15:0] z;
      logic signed [15:0] y;
      logic signed [15:0] x;          // Bits 15:0.
    } focus;
  } pattern_word_t;

endpackage

// ==== logic/stm_regs.sv ====
module stm_regs (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic [7:0]             awaddr,
  input  logic                   awvalid,
  output logic                   awready,
  input  logic [31:0]            wdata,
  input  logic [3:0]             wstrb,
  input  logic                   wvalid,
  output logic                   wready,
  output logic                   bvalid,
  output logic [1:0]             bresp,
  input  logic                   bready,
  input  logic [7:0]             araddr,
  input  logic                   arvalid,
  output logic                   arready,
  output logic                   rvalid,
  output logic [31:0]            rdata,
  output logic [1:0]             rresp,
  input  logic                   rready,
  output logic                   gain_mode,
  output logic [4:0]             cycle,
  output logic [31:0]            freq_div,
  output logic [15:0]            sound_speed,
  output logic                   mem_we,
  output logic [7:0]             mem_waddr,
  output stm_pkg::pattern_word_t mem_wdata
);
  import stm_pkg::*;

  logic [31:0] mem_lo;
  logic [31:0] mem_hi;
  logic        aw_hs;
  logic        ar_hs;
  logic        commit;

  // Byte lane merge of new data over the old register value.
  function automatic logic [31:0] merge(logic [31:0] old_val, logic [31:0] new_val,
                                        logic [3:0] strb);
    logic [31:0] res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b+:8] = new_val[8*b+:8];
    end
    return res;
  endfunction

  assign aw_hs  = awvalid && awready;  // W completes on the same edge.
  assign ar_hs  = arvalid && arready;
  assign commit = aw_hs && (awaddr == reg_mem_addr) && wstrb[0];
  assign bresp  = 2'b00;
  assign rresp  = 2'b00;

  // ========================================
  // Write channel
  // ========================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      awready     <= 1'b0;
      wready      <= 1'b0;
      bvalid      <= 1'b0;
      mem_we      <= 1'b0;
      mem_waddr   <= '0;
      gain_mode   <= 1'b0;
      cycle       <= '0;
      freq_div    <= '0;
      sound_speed <= '0;
      mem_lo      <= '0;
      mem_hi      <= '0;
    end else begin
      awready <= 1'b0;
      wready  <= 1'b0;
      mem_we  <= 1'b0;
      // Accept only when both halves are present and no response is pending.
      if (awvalid && wvalid && !awready && !bvalid) begin
        awready <= 1'b1;
        wready  <= 1'b1;
      end
      if (aw_hs) begin
        bvalid <= 1'b1;
        case (awaddr)
          reg_ctrl:        if (wstrb[0]) gain_mode <= wdata[0];
          reg_cycle:       if (wstrb[0]) cycle <= wdata[4:0];
          reg_freq_div:    freq_div <= merge(freq_div, wdata, wstrb);
          reg_sound_speed: sound_speed <= 16'(merge({16'b0, sound_speed}, wdata, wstrb));
          reg_mem_lo:      mem_lo <= merge(mem_lo, wdata, wstrb);
          reg_mem_hi:      mem_hi <= merge(mem_hi, wdata, wstrb);
          reg_mem_addr: begin
            if (wstrb[0]) begin
              mem_we    <= 1'b1;  // Memory writes on the next edge.
              mem_waddr <= wdata[7:0];
            end
          end
          default: ;
        endcase
      end else if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (commit) mem_wdata <= {mem_hi, mem_lo};
  end

  // ========================================
  // Read channel
  // ========================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
      rdata   <= '0;
    end else begin
      arready <= arvalid && !arready && !rvalid;
      if (ar_hs) begin
        rvalid <= 1'b1;
        case (araddr)
          reg_ctrl:        rdata <= {31'b0, gain_mode};
          reg_cycle:       rdata <= {27'b0, cycle};
          reg_freq_div:    rdata <= freq_div;
          reg_sound_speed: rdata <= {16'b0, sound_speed};
          reg_mem_lo:      rdata <= mem_lo;
          reg_mem_hi:      rdata <= mem_hi;
          reg_mem_addr:    rdata <= {24'b0, mem_waddr};
          default:         rdata <= '0;  // Unknown offset.
        endcase
      end else if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
    end
  end

endmodule

// ==== logic/stm_memory.sv ====
module stm_memory (
  input  logic                   clk,
  input  logic                   we,
  input  logic [7:0]             waddr,
  input  stm_pkg::pattern_word_t wdata,
  input  logic [7:0]             raddr,
  output stm_pkg::pattern_word_t rdata
);
  import stm_pkg::*;

  // Gain patterns use 16 words each, focus patterns one.
  pattern_word_t mem [mem_depth];

  // Host side write port.
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Operator side read port with one cycle latency.
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

// ==== logic/stm_sampler.sv ====
module stm_sampler (
  input  logic        clk,
  input  logic        arst_n,
  input  logic [4:0]  cycle,
  input  logic [31:0] freq_div,
  output logic [3:0]  idx
);

  logic [31:0] div_cnt;
  logic        step;

  // A freq_div of 0 behaves like 1.
  assign step = (div_cnt + 32'd1 >= freq_div);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      div_cnt <= '0;
      idx     <= '0;
    end else begin
      div_cnt <= step ? '0 : div_cnt + 32'd1;
      if (cycle == 5'd0) begin
        idx <= '0;  // No sequence programmed.
      end else if (step) begin
        // Wrap after cycle - 1.
        idx <= ({1'b0, idx} + 5'd1 >= cycle) ? '0 : idx + 4'd1;
      end
    end
  end

endmodule

// ==== logic/stm_gain_operator.sv ====
module stm_gain_operator (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   update,
  input  logic [3:0]             idx,
  input  stm_pkg::pattern_word_t rdata,
  output logic [7:0]             raddr,
  output logic [7:0]             intensity,
  output logic [7:0]             phase,
  output logic                   dout_valid,
  output logic [3:0]             trans_idx
);
  import stm_pkg::*;

  logic       busy_q;
  logic [3:0] pat_q;
  logic [3:0] cnt_q;     // Next transducer to read.
  logic       rd_vld_q;  // Memory word arrives this cycle.
  logic [3:0] rd_tr_q;
  logic       start;

  assign start = update && !busy_q;  // Updates inside a burst are dropped.

  // Word 0 is addressed straight from idx so that data returns a cycle early.
  assign raddr = busy_q ? {pat_q, cnt_q} : {idx, 4'd0};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy_q     <= 1'b0;
      cnt_q      <= '0;
      rd_vld_q   <= 1'b0;
      dout_valid <= 1'b0;
    end else begin
      rd_vld_q   <= start || busy_q;
      dout_valid <= rd_vld_q;
      if (start) begin
        busy_q <= 1'b1;
        cnt_q  <= 4'd1;
      end else if (busy_q) begin
        cnt_q <= cnt_q + 4'd1;
        if (cnt_q == last_trans) busy_q <= 1'b0;
      end
    end
  end

  // Pattern latch and output stage.
  always_ff @(posedge clk) begin
    if (start) begin
      pat_q   <= idx;
      rd_tr_q <= '0;
    end else if (busy_q) begin
      rd_tr_q <= cnt_q;
    end
    if (rd_vld_q) begin
      intensity <= rdata.gain.intensity;
      phase     <= rdata.gain.phase;
      trans_idx <= rd_tr_q;
    end
  end

endmodule

// ==== logic/stm_isqrt.sv ====
module stm_isqrt (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        start,
  input  logic [31:0] radicand,
  output logic [15:0] root,
  output logic        done
);

  logic signed [21:0] rem_q;   // Partial remainder that may go negative.
  logic [15:0]        q_q;
  logic [31:0]        rad_q;   // Bit pairs shift out of the top.
  logic [3:0]         cnt_q;
  logic               busy_q;
  logic signed [21:0] rem_sh;
  logic signed [21:0] rem_nx;

  // Non-restoring step subtracts on a positive remainder and adds otherwise.
  always_comb begin
    rem_sh = {rem_q[19:0], rad_q[31:30]};
    if (!rem_q[21]) begin
      rem_nx = rem_sh - signed'({4'b0, q_q, 2'b01});
    end else begin
      rem_nx = rem_sh + signed'({4'b0, q_q, 2'b11});
    end
  end

  assign root = q_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rem_q  <= '0;
      q_q    <= '0;
      rad_q  <= '0;
      cnt_q  <= '0;
      busy_q <= 1'b0;
      done   <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start && !busy_q) begin
        rem_q  <= '0;  // Load cycle.
        q_q    <= '0;
        rad_q  <= radicand;
        cnt_q  <= 4'd15;
        busy_q <= 1'b1;
      end else if (busy_q) begin
        rem_q <= rem_nx;
        q_q   <= {q_q[14:0], ~rem_nx[21]};
        rad_q <= {rad_q[29:0], 2'b00};
        cnt_q <= cnt_q - 4'd1;
        if (cnt_q == 4'd0) begin
          busy_q <= 1'b0;
          done   <= 1'b1;  // 16 root bits done.
        end
      end
    end
  end

endmodule

// ==== logic/stm_focus_operator.sv ====
module stm_focus_operator (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   update,
  input  logic [3:0]             idx,
  input  stm_pkg::pattern_word_t rdata,
  input  logic [15:0]            sound_speed,
  output logic [7:0]             raddr,
  output logic [7:0]             intensity,
  output logic [7:0]             phase,
  output logic                   dout_valid,
  output logic [3:0]             trans_idx
);
  import stm_pkg::*;

  logic [2:0]         state_q;
  logic [3:0]         pat_q;
  logic signed [15:0] fx_q, fy_q, fz_q;
  logic signed [16:0] tx, ty;
  logic signed [16:0] dx, dy, dz;
  logic signed [33:0] dx_sq, dy_sq, dz_sq;
  logic [33:0]        dist_sq;
  logic [31:0]        radicand;
  logic [15:0]        root;
  logic               root_done;
  logic [31:0]        prod;

  // Transducer position from its grid index with z at 0.
  always_comb begin
    tx    = 17'((32'(trans_idx) % grid_cols) * trans_pitch);
    ty    = 17'((32'(trans_idx) / grid_cols) * trans_pitch);
    dx    = {fx_q[15], fx_q} - tx;
    dy    = {fy_q[15], fy_q} - ty;
    dz    = {fz_q[15], fz_q};
    dx_sq = 34'(dx) * 34'(dx);
    dy_sq = 34'(dy) * 34'(dy);
    dz_sq = 34'(dz) * 34'(dz);
  end

  assign dist_sq    = 34'(dx_sq + dy_sq + dz_sq);
  assign radicand   = dist_sq[31:0];  // Three squared 17 bit offsets fit 32 bits.
  assign prod       = 32'(root) * 32'(sound_speed);
  assign raddr      = {4'b0, pat_q};  // One focal point per pattern.
  assign dout_valid = (state_q == st_out);

  stm_isqrt stm_isqrt (
    .clk     (clk),
    .arst_n  (arst_n),
    .start   (state_q == st_square),
    .radicand(radicand),
    .root    (root),
    .done    (root_done)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q   <= st_idle;
      trans_idx <= '0;
    end else begin
      case (state_q)
        st_idle:   if (update) state_q <= st_fetch;  // Busy otherwise.
        st_fetch:  state_q <= st_load;               // Memory sees raddr.
        st_load: begin
          trans_idx <= '0;
          state_q   <= st_square;
        end
        st_square: state_q <= st_root;
        st_root:   if (root_done) state_q <= st_out;
        st_out: begin
          if (trans_idx == last_trans) begin
            state_q <= st_idle;
          end else begin
            trans_idx <= trans_idx + 4'd1;
            state_q   <= st_square;
          end
        end
        default:   state_q <= st_idle;
      endcase
    end
  end

  // Focal point capture and phase output.
  always_ff @(posedge clk) begin
    if (state_q == st_idle && update) pat_q <= idx;
    if (state_q == st_load) begin
      fx_q      <= rdata.focus.x;
      fy_q      <= rdata.focus.y;
      fz_q      <= rdata.focus.z;
      intensity <= rdata.focus.intensity;
    end
    if (state_q == st_root && root_done) phase <= prod[15:8];
  end

endmodule

// ==== logic/stm_operator.sv ====
module stm_operator (
  input  logic        clk,
  input  logic        arst_n,
  input  logic [7:0]  awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  input  logic        wvalid,
  output logic        wready,
  output logic        bvalid,
  output logic [1:0]  bresp,
  input  logic        bready,
  input  logic [7:0]  araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic        rvalid,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  input  logic        rready,
  input  logic        update,
  output logic [7:0]  intensity,
  output logic [7:0]  phase,
  output logic        dout_valid,
  output logic [3:0]  trans_idx,
  output logic [3:0]  idx
);
  import stm_pkg::*;

  logic          gain_mode;
  logic [4:0]    cycle;
  logic [31:0]   freq_div;
  logic [15:0]   sound_speed;
  logic          mem_we;
  logic [7:0]    mem_waddr;
  pattern_word_t mem_wdata;
  pattern_word_t mem_rdata;
  logic [7:0]    mem_raddr;

  logic [7:0] raddr_gain, raddr_focus;
  logic [7:0] intensity_gain, intensity_focus;
  logic [7:0] phase_gain, phase_focus;
  logic       dout_valid_gain, dout_valid_focus;
  logic [3:0] trans_idx_gain, trans_idx_focus;

  // ========================================
  // Mode select
  // ========================================
  assign mem_raddr  = gain_mode ? raddr_gain : raddr_focus;
  assign intensity  = gain_mode ? intensity_gain : intensity_focus;
  assign phase      = gain_mode ? phase_gain : phase_focus;
  assign dout_valid = gain_mode ? dout_valid_gain : dout_valid_focus;
  assign trans_idx  = gain_mode ? trans_idx_gain : trans_idx_focus;

  stm_regs stm_regs (
    .clk(clk), .arst_n(arst_n),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bvalid(bvalid), .bresp(bresp), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready),
    .gain_mode(gain_mode), .cycle(cycle), .freq_div(freq_div),
    .sound_speed(sound_speed),
    .mem_we(mem_we), .mem_waddr(mem_waddr), .mem_wdata(mem_wdata)
  );

  stm_memory stm_memory (
    .clk(clk), .we(mem_we), .waddr(mem_waddr), .wdata(mem_wdata),
    .raddr(mem_raddr), .rdata(mem_rdata)
  );

  stm_sampler stm_sampler (
    .clk(clk), .arst_n(arst_n), .cycle(cycle), .freq_div(freq_div), .idx(idx)
  );

  // Only the operator of the active mode sees update.
  stm_gain_operator stm_gain_operator (
    .clk(clk), .arst_n(arst_n), .update(update && gain_mode), .idx(idx),
    .rdata(mem_rdata), .raddr(raddr_gain),
    .intensity(intensity_gain), .phase(phase_gain),
    .dout_valid(dout_valid_gain), .trans_idx(trans_idx_gain)
  );

  stm_focus_operator stm_focus_operator (
    .clk(clk), .arst_n(arst_n), .update(update && !gain_mode), .idx(idx),
    .rdata(mem_rdata), .sound_speed(sound_speed), .raddr(raddr_focus),
    .intensity(intensity_focus), .phase(phase_focus),
    .dout_valid(dout_valid_focus), .trans_idx(trans_idx_focus)
  );

endmodule

// ==== dv/tb_stm_operator.sv ====
module tb_stm_operator;
  import stm_pkg::*;

  localparam int num_tests = 7;

  typedef enum logic [2:0] {t_regs, t_gain, t_focus, t_sampler, t_switch} test_kind_t;

  typedef struct packed {
    test_kind_t         kind;
    logic               mode;         // Value written to gain_mode.
    logic [3:0]         pat;
    logic [3:0]         pat2;         // Gain pattern after a mode switch.
    logic [4:0]         cycle;
    logic [31:0]        freq_div;
    logic [15:0]        sound_speed;
    logic signed [15:0] fx;
    logic signed [15:0] fy;
    logic signed [15:0] fz;
    logic [7:0]         fint;
  } test_entry_t;

  logic        clk, arst_n;
  logic [7:0]  awaddr, araddr;
  logic        awvalid, awready, wvalid, wready, bvalid, bready;
  logic [31:0] wdata, rdata;
  logic [3:0]  wstrb;
  logic [1:0]  bresp, rresp;
  logic        arvalid, arready, rvalid, rready;
  logic        update, dout_valid;
  logic [7:0]  intensity, phase;
  logic [3:0]  trans_idx, idx;

  test_entry_t tbl [num_tests];
  integer      seed;
  int          errors;

  // Shadow copy of what the host stored in the pattern memory.
  logic [7:0] gain_i [16][16];
  logic [7:0] gain_p [16][16];
  int         focus_x [16];
  int         focus_y [16];
  int         focus_z [16];
  logic [7:0] focus_i [16];

  stm_operator DUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    #(num_tests * 2000);
    $display("watchdog expired before the tests finished");
    $display("Done: errors found");
    $finish;
  end

  // ========================================
  // Reporting and reference model
  // ========================================
  task automatic report_mismatch(input string name, input int got, input int exp);
    $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
    errors++;
  endtask

  task automatic report_problem(input string msg);
    $display("%s", msg);
    errors++;
  endtask

  function automatic longint int_sqrt(input longint n);
    longint r;
    longint cand;
    r = 0;
    for (int b = 15; b >= 0; b--) begin
      cand = r | (longint'(1) << b);
      if (cand * cand <= n) r = cand;  // Keep the bit if it does not overshoot.
    end
    return r;
  endfunction

  function automatic logic [7:0] focus_phase(input int fx, input int fy, input int fz,
                                             input int tr, input int ss);
    longint dx;
    longint dy;
    longint dist_sq;
    dx      = longint'(fx - (tr % grid_cols) * trans_pitch);
    dy      = longint'(fy - (tr / grid_cols) * trans_pitch);
    dist_sq = dx * dx + dy * dy + longint'(fz) * longint'(fz);
    return 8'((int_sqrt(dist_sq) * longint'(ss)) >> 8);
  endfunction

  function automatic string kind_name(input test_kind_t k);
    case (k)
      t_regs:    return "registers";
      t_gain:    return "gain replay";
      t_focus:   return "focus phase";
      t_sampler: return "sampler";
      default:   return "mode switch";
    endcase
  endfunction

  // ========================================
  // AXI4-Lite driver
  // ========================================
  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic hold_b);
    int waits;
    awaddr  = addr;
    wdata   = data;
    wstrb   = 4'hF;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = !hold_b;
    waits   = 0;
    do begin
      @(negedge clk);
      waits++;
    end while (!awready && waits < 20);
    if (!awready) begin
      report_problem($sformatf("write to offset 0x%0h was not accepted", addr));
      awvalid = 1'b0;
      wvalid  = 1'b0;
      bready  = 1'b1;
      return;
    end
    if (!wready) report_mismatch("wready", int'(wready), 1);
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    if (!bvalid) report_problem("bvalid missing after the write handshake");
    if (bresp != 2'b00) report_mismatch("bresp", int'(bresp), 0);
    if (hold_b) begin
      repeat (3) begin
        @(negedge clk);
        if (!bvalid) report_problem("bvalid dropped while bready was low");
      end
      bready = 1'b1;
    end
    waits = 0;
    while (bvalid && waits < 20) begin
      @(negedge clk);
      waits++;
    end
    if (bvalid) report_problem("bvalid stuck high after bready");
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
    int waits;
    araddr  = addr;
    arvalid = 1'b1;
    data    = '0;
    waits   = 0;
    do begin
      @(negedge clk);
      waits++;
    end while (!arready && waits < 20);
    if (!arready) begin
      report_problem($sformatf("read of offset 0x%0h was not accepted", addr));
      arvalid = 1'b0;
      return;
    end
    @(negedge clk);
    arvalid = 1'b0;
    if (!rvalid) report_problem("rvalid missing one cycle after the read handshake");
    data = rdata;
    if (rresp != 2'b00) report_mismatch("rresp", int'(rresp), 0);
    @(negedge clk);  // Let rvalid drop.
  endtask

  task automatic write_word(input logic [7:0] addr, input logic [31:0] lo,
                            input logic [31:0] hi);
    axi_write(reg_mem_lo, lo, 1'b0);
    axi_write(reg_mem_hi, hi, 1'b0);
    axi_write(reg_mem_addr, 32'(addr), 1'b0);  // Commits the word.
  endtask

  task automatic program_regs(input test_entry_t e, input logic hold_ctrl);
    axi_write(reg_cycle, 32'(e.cycle), 1'b0);
    axi_write(reg_freq_div, e.freq_div, 1'b0);
    axi_write(reg_sound_speed, 32'(e.sound_speed), 1'b0);
    axi_write(reg_ctrl, 32'(e.mode), hold_ctrl);
  endtask

  // ========================================
  // Output burst checker
  // ========================================
  task automatic run_burst(input logic gain, input logic [3:0] pat, input logic poke,
                           input int ss);
    int         waits;
    int         cyc;
    int         beats;
    int         quiet;
    logic [7:0] exp_i;
    logic [7:0] exp_p;
    waits = 0;
    while (idx != pat && waits < 200) begin
      @(negedge clk);
      waits++;
    end
    if (idx != pat) begin
      report_problem($sformatf("idx never reached pattern %0d", pat));
      return;
    end
    update = 1'b1;  // Sampled together with idx on the next rising edge.
    cyc    = 0;
    beats  = 0;
    quiet  = 0;
    while (cyc < 500 && !(beats == num_trans && quiet >= 24)) begin
      @(negedge clk);
      cyc++;
      update = poke && (cyc == 40);  // Second request lands inside the burst.
      if (dout_valid) begin
        if (gain && cyc != beats + 2) begin
          report_problem($sformatf("gain beat %0d came at cycle %0d", beats, cyc));
        end
        if (beats >= num_trans) begin
          if (beats == num_trans) report_problem("output beat after the end of the burst");
        end else begin
          exp_i = gain ? gain_i[pat][beats] : focus_i[pat];
          exp_p = gain ? gain_p[pat][beats]
                       : focus_phase(focus_x[pat], focus_y[pat], focus_z[pat], beats, ss);
          if (int'(trans_idx) != beats) report_mismatch("trans_idx", int'(trans_idx), beats);
          if (intensity != exp_i) report_mismatch("intensity", int'(intensity), int'(exp_i));
          if (phase != exp_p) report_mismatch("phase", int'(phase), int'(exp_p));
        end
        beats++;
        quiet = 0;
      end else begin
        quiet++;
      end
    end
    if (beats < num_trans) begin
      report_problem($sformatf("burst gave %0d of 16 beats", beats));
    end
  endtask

  // ========================================
  // Tests
  // ========================================
  task automatic test_regs(input test_entry_t e);
    logic [31:0] val;
    if (dout_valid || awready || bvalid || rvalid) begin
      report_problem("outputs not idle after reset");
    end
    axi_read(reg_freq_div, val);
    if (val != 0) report_mismatch("freq_div", int'(val), 0);
    program_regs(e, 1'b1);
    axi_read(reg_cycle, val);
    if (val != 32'(e.cycle)) report_mismatch("cycle", int'(val), int'(e.cycle));
    axi_read(reg_freq_div, val);
    if (val != e.freq_div) report_mismatch("freq_div", int'(val), int'(e.freq_div));
    axi_read(reg_sound_speed, val);
    if (val != 32'(e.sound_speed)) begin
      report_mismatch("sound_speed", int'(val), int'(e.sound_speed));
    end
    axi_read(reg_ctrl, val);
    if (val != 32'(e.mode)) report_mismatch("ctrl", int'(val), int'(e.mode));
    axi_read(8'h1C, val);  // Unused offset.
    if (val != 0) report_mismatch("rdata", int'(val), 0);
  endtask

  task automatic test_gain(input test_entry_t e);
    logic [31:0] lo;
    logic [31:0] hi;
    program_regs(e, 1'b0);
    for (int k = 0; k < num_trans; k++) begin
      lo = $random(seed);  // Reserved bits get random data too.
      hi = $random(seed);
      gain_i[e.pat][k] = lo[7:0];
      gain_p[e.pat][k] = lo[15:8];
      write_word({e.pat, 4'(k)}, lo, hi);
    end
    run_burst(1'b1, e.pat, 1'b0, int'(e.sound_speed));
  endtask

  task automatic test_focus(input test_entry_t e);
    focus_x[e.pat] = int'(e.fx);
    focus_y[e.pat] = int'(e.fy);
    focus_z[e.pat] = int'(e.fz);
    focus_i[e.pat] = e.fint;
    write_word({4'd0, e.pat}, {e.fy, e.fx}, {8'h00, e.fint, e.fz});
    program_regs(e, 1'b0);
    run_burst(1'b0, e.pat, 1'b0, int'(e.sound_speed));
  endtask

  task automatic test_sampler(input test_entry_t e);
    int clocks;
    int steps;
    int prev;
    int changes;
    program_regs(e, 1'b0);
    // Two steps to line up with the new divider.
    changes = 0;
    clocks  = 0;
    prev    = int'(idx);
    while (changes < 2 && clocks < 100) begin
      @(negedge clk);
      clocks++;
      if (int'(idx) != prev) begin
        changes++;
        prev = int'(idx);
      end
    end
    if (changes < 2) begin
      report_problem("idx does not advance");
      return;
    end
    steps  = 0;
    clocks = 0;
    while (steps < 6 && clocks <= int'(e.freq_div) + 2) begin
      @(negedge clk);
      clocks++;
      if (int'(idx) != prev) begin
        if (clocks != int'(e.freq_div)) begin
          report_mismatch("idx period", clocks, int'(e.freq_div));
        end
        if (int'(idx) != (prev + 1) % int'(e.cycle)) begin
          report_mismatch("idx", int'(idx), (prev + 1) % int'(e.cycle));
        end
        prev   = int'(idx);
        clocks = 0;
        steps++;
      end
    end
    if (steps < 6) report_problem("idx stopped advancing");
  endtask

  task automatic test_switch(input test_entry_t e);
    program_regs(e, 1'b0);
    run_burst(1'b0, e.pat, 1'b1, int'(e.sound_speed));
    axi_write(reg_ctrl, 32'd1, 1'b0);
    run_burst(1'b1, e.pat2, 1'b0, int'(e.sound_speed));
  endtask

  task automatic add_entry(input int i, input test_kind_t kind, input int mode, input int pat,
                           input int pat2, input int cyc, input int freq, input int ss,
                           input int fx, input int fy, input int fz, input int fint);
    tbl[i].kind        = kind;
    tbl[i].mode        = 1'(mode);
    tbl[i].pat         = 4'(pat);
    tbl[i].pat2        = 4'(pat2);
    tbl[i].cycle       = 5'(cyc);
    tbl[i].freq_div    = 32'(freq);
    tbl[i].sound_speed = 16'(ss);
    tbl[i].fx          = 16'(fx);
    tbl[i].fy          = 16'(fy);
    tbl[i].fz          = 16'(fz);
    tbl[i].fint        = 8'(fint);
  endtask

  task automatic load_table();
    // Index, kind, mode, pattern, gain pattern, cycle, freq_div, sound speed,
    // focus x, y, z and focus intensity.
    add_entry(0, t_regs,    1, 0, 0, 16, 3, 'h1234,    0,    0,   0, 'h00);
    add_entry(1, t_gain,    1, 1, 0, 16, 3,     100,    0,    0,   0, 'h00);
    add_entry(2, t_gain,    1, 9, 0, 16, 2,     100,    0,    0,   0, 'h00);
    add_entry(3, t_focus,   0, 2, 0, 16, 3,     343,  100,  -50, 200, 'hA5);
    add_entry(4, t_focus,   0, 5, 0, 16, 2,    1500, -300, -120, 150, 'h3C);
    add_entry(5, t_sampler, 0, 0, 0,  3, 5,     343,    0,    0,   0, 'h00);
    add_entry(6, t_switch,  0, 2, 1, 16, 2,     343,    0,    0,   0, 'h00);
  endtask

  // ========================================
  // Main sequence
  // ========================================
  initial begin
    int err_before;
    int passed;
    int failed;
    arst_n  = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b1;
    update  = 1'b0;
    seed    = 42;
    errors  = 0;
    passed  = 0;
    failed  = 0;
    load_table();
    repeat (4) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    for (int t = 0; t < num_tests; t++) begin
      err_before = errors;
      case (tbl[t].kind)
        t_regs:    test_regs(tbl[t]);
        t_gain:    test_gain(tbl[t]);
        t_focus:   test_focus(tbl[t]);
        t_sampler: test_sampler(tbl[t]);
        default:   test_switch(tbl[t]);
      endcase
      if (errors == err_before) begin
        passed++;
        $display("test %0d %s: ok", t, kind_name(tbl[t].kind));
      end else begin
        failed++;
        $display("test %0d %s: %0d errors", t, kind_name(tbl[t].kind), errors - err_before);
      end
    end
    $display("%0d tests passed, %0d failed", passed, failed);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== list.f ====
logic/stm_pkg.sv
logic/stm_regs.sv
logic/stm_memory.sv
logic/stm_sampler.sv
logic/stm_gain_operator.sv
logic/stm_isqrt.sv
logic/stm_focus_operator.sv
logic/stm_operator.sv
dv/tb_stm_operator.sv

// ==== Makefile ====
# Verilator simulation of the STM engine.
SRCS := $(shell cat list.f)

obj_dir/Vtb_stm_operator: list.f $(SRCS)
	verilator --binary --timing -j 0 --top-module tb_stm_operator -f list.f

run: obj_dir/Vtb_stm_operator
	out=$$(./obj_dir/Vtb_stm_operator); \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Done: no errors'

clean:
	rm -rf obj_dir

.PHONY: run clean
